/* rtl/i2c_switch_pkg.sv */
package i2c_switch_pkg;

    // one filtered bus line
    // level is the delayed filtered value, rose/fell are single-cycle strobes
    typedef struct packed {
        logic level;
        logic rose;
        logic fell;
    } line_state_t;

    // both lines of one bus side
    typedef struct packed {
        line_state_t scl;
        line_state_t sda;
    } side_lines_t;

    // open-drain enables of one side where 1 means released
    typedef struct packed {
        logic scl_oen;
        logic sda_oen;
    } pad_drive_t;

    // samples in the glitch filter shift register
    parameter int DEF_FILTER_LEN = 8;

    // rise-time windows after a release in clk cycles
    parameter int DEF_SDA_HOLD_CYCLES = 100;
    parameter int DEF_SCL_HOLD_CYCLES = 100;

    // hold counters must cover both windows
    parameter int HOLD_CNT_W = 8;

endpackage

/* rtl/pad_filter.sv */
`timescale 1ns/1ns

module pad_filter #(
    parameter int FILTER_LEN = i2c_switch_pkg::DEF_FILTER_LEN
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        scl_pad_i,
    input  logic                        sda_pad_i,
    output i2c_switch_pkg::side_lines_t lines_o
);

    // index 0 is scl, index 1 is sda
    logic [1:0]                 raw;
    logic [1:0][FILTER_LEN-1:0] samples;
    logic [1:0]                 filt;
    logic [1:0]                 dly_0;
    logic [1:0]                 dly_1;
    logic [1:0]                 rose;
    logic [1:0]                 fell;

    assign raw = {sda_pad_i, scl_pad_i};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            samples <= '1;
        end else begin
            for (int i = 0; i < 2; i++) begin
                samples[i] <= {samples[i][FILTER_LEN-2:0], raw[i]};
            end
        end
    end

    // newest sample left out; the level moves only on a unanimous history
    // and holds on anything mixed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            filt <= '1;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (&samples[i][FILTER_LEN-1:1]) begin
                    filt[i] <= 1'b1;
                end else if (~|samples[i][FILTER_LEN-1:1]) begin
                    filt[i] <= 1'b0;
                end
            end
        end
    end

    // two-stage delay line for edge detection
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dly_0 <= '1;
            dly_1 <= '1;
        end else begin
            dly_0 <= filt;
            dly_1 <= dly_0;
        end
    end

    assign rose = dly_0 & ~dly_1;
    assign fell = ~dly_0 & dly_1;

    assign lines_o.scl.level = dly_0[0];
    assign lines_o.scl.rose  = rose[0];
    assign lines_o.scl.fell  = fell[0];
    assign lines_o.sda.level = dly_0[1];
    assign lines_o.sda.rose  = rose[1];
    assign lines_o.sda.fell  = fell[1];

endmodule

/* rtl/sda_direction_fsm.sv */
`timescale 1ns/1ns

module sda_direction_fsm #(
    parameter int SDA_HOLD_CYCLES = i2c_switch_pkg::DEF_SDA_HOLD_CYCLES
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  i2c_switch_pkg::line_state_t m_sda_i,
    input  i2c_switch_pkg::line_state_t s_sda_i,
    output logic                        m_sda_oen_o,
    output logic                        s_sda_oen_o
);

    localparam int CW = i2c_switch_pkg::HOLD_CNT_W;
    localparam logic [CW-1:0] HOLD_LAST = CW'(SDA_HOLD_CYCLES);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_MTOS = 2'd1;
    localparam logic [1:0] ST_STOM = 2'd2;
    localparam logic [1:0] ST_HOLD = 2'd3;

    logic [1:0]    state_q;
    logic [1:0]    state_d;
    logic [CW-1:0] hold_cnt;
    logic          hold_done;

    // rise-time window counted only while in HOLD
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_cnt <= '0;
        end else if (state_q != ST_HOLD) begin
            hold_cnt <= '0;
        end else if (!hold_done) begin
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

    assign hold_done = (hold_cnt == HOLD_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // master side checked first so it wins a simultaneous low
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (!m_sda_i.level) begin
                    state_d = ST_MTOS;
                end else if (!s_sda_i.level) begin
                    state_d = ST_STOM;
                end
            end
            ST_MTOS: begin
                if (m_sda_i.level) begin
                    state_d = ST_HOLD;
                end
            end
            ST_STOM: begin
                if (s_sda_i.level) begin
                    state_d = ST_HOLD;
                end
            end
            ST_HOLD: begin
                if (hold_done) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // enables registered from the next state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_sda_oen_o <= 1'b1;
            s_sda_oen_o <= 1'b1;
        end else begin
            m_sda_oen_o <= (state_d != ST_STOM);
            s_sda_oen_o <= (state_d != ST_MTOS);
        end
    end

endmodule

/* rtl/scl_forward_fsm.sv */
`timescale 1ns/1ns

module scl_forward_fsm #(
    parameter int SCL_HOLD_CYCLES = i2c_switch_pkg::DEF_SCL_HOLD_CYCLES
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  i2c_switch_pkg::side_lines_t m_lines_i,
    output logic                        m_scl_oen_o,
    output logic                        s_scl_oen_o
);

    localparam int CW = i2c_switch_pkg::HOLD_CNT_W;
    localparam logic [CW-1:0] HOLD_LAST = CW'(SCL_HOLD_CYCLES);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_FORWARD = 2'd1;
    localparam logic [1:0] ST_HOLD    = 2'd2;

    logic [1:0]    state_q;
    logic [1:0]    state_d;
    logic [CW-1:0] hold_cnt;
    logic          hold_done;
    logic          stop_det;

    // sda rising while scl is high
    assign stop_det = m_lines_i.sda.rose & m_lines_i.scl.level;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_cnt <= '0;
        end else if (state_q != ST_HOLD) begin
            hold_cnt <= '0;
        end else if (!hold_done) begin
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

    assign hold_done = (hold_cnt == HOLD_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (!m_lines_i.scl.level) begin
                    state_d = ST_FORWARD;
                end
            end
            ST_FORWARD: begin
                if (stop_det) begin
                    state_d = ST_HOLD;
                end
            end
            ST_HOLD: begin
                if (hold_done) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // slave scl follows the master level only while forwarding
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_scl_oen_o <= 1'b1;
        end else if (state_d == ST_FORWARD) begin
            s_scl_oen_o <= m_lines_i.scl.level;
        end else begin
            s_scl_oen_o <= 1'b1;
        end
    end

    // no clock stretching toward the master, so this side never pulls low
    assign m_scl_oen_o = 1'b1;

endmodule

/* rtl/i2c_switch_top.sv */
`timescale 1ns/1ns

module i2c_switch_top #(
    parameter int FILTER_LEN      = i2c_switch_pkg::DEF_FILTER_LEN,
    parameter int SDA_HOLD_CYCLES = i2c_switch_pkg::DEF_SDA_HOLD_CYCLES,
    parameter int SCL_HOLD_CYCLES = i2c_switch_pkg::DEF_SCL_HOLD_CYCLES
) (
    input  logic clk,
    input  logic rst_n,
    input  logic m_scl_pad_i,
    input  logic m_sda_pad_i,
    input  logic s_scl_pad_i,
    input  logic s_sda_pad_i,
    output logic m_scl_padoen_o,
    output logic m_sda_padoen_o,
    output logic s_scl_padoen_o,
    output logic s_sda_padoen_o
);

    i2c_switch_pkg::side_lines_t m_lines;
    i2c_switch_pkg::side_lines_t s_lines;
    wire i2c_switch_pkg::pad_drive_t m_drive;
    wire i2c_switch_pkg::pad_drive_t s_drive;

    pad_filter #(.FILTER_LEN(FILTER_LEN)) u_m_filter (
        .clk       (clk),
        .rst_n     (rst_n),
        .scl_pad_i (m_scl_pad_i),
        .sda_pad_i (m_sda_pad_i),
        .lines_o   (m_lines)
    );

    pad_filter #(.FILTER_LEN(FILTER_LEN)) u_s_filter (
        .clk       (clk),
        .rst_n     (rst_n),
        .scl_pad_i (s_scl_pad_i),
        .sda_pad_i (s_sda_pad_i),
        .lines_o   (s_lines)
    );

    sda_direction_fsm #(.SDA_HOLD_CYCLES(SDA_HOLD_CYCLES)) u_sda_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .m_sda_i     (m_lines.sda),
        .s_sda_i     (s_lines.sda),
        .m_sda_oen_o (m_drive.sda_oen),
        .s_sda_oen_o (s_drive.sda_oen)
    );

    // slave scl is not read while stretch handling is absent
    scl_forward_fsm #(.SCL_HOLD_CYCLES(SCL_HOLD_CYCLES)) u_scl_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .m_lines_i   (m_lines),
        .m_scl_oen_o (m_drive.scl_oen),
        .s_scl_oen_o (s_drive.scl_oen)
    );

    assign m_scl_padoen_o = m_drive.scl_oen;
    assign m_sda_padoen_o = m_drive.sda_oen;
    assign s_scl_padoen_o = s_drive.scl_oen;
    assign s_sda_padoen_o = s_drive.sda_oen;

endmodule

/* sim/tb_i2c_switch.sv */
`timescale 1ns/1ns

module tb_i2c_switch;

    localparam int FILTER_LEN      = i2c_switch_pkg::DEF_FILTER_LEN;
    localparam int SDA_HOLD_CYCLES = i2c_switch_pkg::DEF_SDA_HOLD_CYCLES;
    localparam int SCL_HOLD_CYCLES = i2c_switch_pkg::DEF_SCL_HOLD_CYCLES;
    localparam int WAIT_LIMIT      = 4 * FILTER_LEN + SDA_HOLD_CYCLES;
    localparam int GAP_CYCLES      = SDA_HOLD_CYCLES + 4 * FILTER_LEN;

    localparam logic [31:0] LFSR_SEED = 32'd93477;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    // bit positions in oen_all
    localparam int S_SDA = 0;
    localparam int S_SCL = 1;
    localparam int M_SDA = 2;
    localparam int M_SCL = 3;
    localparam logic [3:0] ALL_OEN = 4'b1111;
    localparam logic [3:0] SDA_OEN = 4'b0101;
    localparam logic [3:0] SCL_OEN = 4'b1010;

    logic        clk;
    logic        rst_n;
    logic        m_dev_scl;
    logic        m_dev_sda;
    logic        s_dev_scl;
    logic        s_dev_sda;
    logic        m_scl_pad;
    logic        m_sda_pad;
    logic        s_scl_pad;
    logic        s_sda_pad;
    logic        m_scl_padoen;
    logic        m_sda_padoen;
    logic        s_scl_padoen;
    logic        s_sda_padoen;
    logic [3:0]  oen_all;
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          tests;
    int          cmp_idx_q[$];
    logic        cmp_exp_q[$];
    event        cmp_ev;

    // open-drain wired-AND of device drive and switch enable
    assign m_scl_pad = m_dev_scl & m_scl_padoen;
    assign m_sda_pad = m_dev_sda & m_sda_padoen;
    assign s_scl_pad = s_dev_scl & s_scl_padoen;
    assign s_sda_pad = s_dev_sda & s_sda_padoen;
    assign oen_all   = {m_scl_padoen, m_sda_padoen, s_scl_padoen, s_sda_padoen};

    i2c_switch_top #(
        .FILTER_LEN      (FILTER_LEN),
        .SDA_HOLD_CYCLES (SDA_HOLD_CYCLES),
        .SCL_HOLD_CYCLES (SCL_HOLD_CYCLES)
    ) i2c_switch_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .m_scl_pad_i    (m_scl_pad),
        .m_sda_pad_i    (m_sda_pad),
        .s_scl_pad_i    (s_scl_pad),
        .s_sda_pad_i    (s_sda_pad),
        .m_scl_padoen_o (m_scl_padoen),
        .m_sda_padoen_o (m_sda_padoen),
        .s_scl_padoen_o (s_scl_padoen),
        .s_sda_padoen_o (s_sda_padoen)
    );

    always #50 clk = ~clk;

    // galois lfsr stepped once per bit taken
    function automatic logic rand_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        return b;
    endfunction

    // a low on the driving side is copied to the far side
    function automatic logic far_oen(input logic m_drv, input logic s_drv,
                                     input logic from_slave);
        return from_slave ? s_drv : m_drv;
    endfunction

    function automatic string oen_name(input int idx);
        case (idx)
            S_SDA:   return "s_sda_padoen_o";
            S_SCL:   return "s_scl_padoen_o";
            M_SDA:   return "m_sda_padoen_o";
            default: return "m_scl_padoen_o";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected 0x%0h got 0x%0h", name, exp, got);
        end
    endtask

    always begin : compare_proc
        int   idx;
        logic exp_bit;
        @(cmp_ev);
        while (cmp_idx_q.size() > 0) begin
            idx = cmp_idx_q.pop_front();
            exp_bit = cmp_exp_q.pop_front();
            check_value(oen_name(idx), 32'(oen_all[idx]), 32'(exp_bit));
        end
    end

    task automatic run_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic expect_enables(input logic [3:0] mask, input logic [3:0] exp);
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                cmp_idx_q.push_back(i);
                cmp_exp_q.push_back(exp[i]);
            end
        end
        -> cmp_ev;
        @(negedge clk);
    endtask

    // stops at the first mismatch
    task automatic watch_enables(input logic [3:0] mask, input logic [3:0] exp,
                                 input int cycles);
        int err_before;
        err_before = errors;
        for (int c = 0; c < cycles && errors == err_before; c++) begin
            expect_enables(mask, exp);
        end
    endtask

    task automatic wait_enable(input int idx, input logic val);
        int n;
        n = 0;
        while (oen_all[idx] !== val && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (oen_all[idx] !== val) begin
            errors++;
            $display("timeout: %s did not reach %0b within %0d cycles",
                     oen_name(idx), val, WAIT_LIMIT);
        end
    endtask

    // setup time afterwards lets the far side settle before scl moves
    task automatic drive_sda(input logic from_slave, input logic b);
        int         far;
        logic [3:0] exp;
        if (from_slave) begin
            s_dev_sda = b;
            far = M_SDA;
        end else begin
            m_dev_sda = b;
            far = S_SDA;
        end
        exp = SDA_OEN;
        exp[far] = far_oen(m_dev_sda, s_dev_sda, from_slave);
        wait_enable(far, exp[far]);
        expect_enables(SDA_OEN, exp);
        run_cycles(2 * FILTER_LEN);
    endtask

    task automatic set_scl(input logic b);
        logic [3:0] exp;
        m_dev_scl = b;
        exp = SCL_OEN;
        exp[S_SCL] = far_oen(b, s_dev_scl, 1'b0);
        wait_enable(S_SCL, exp[S_SCL]);
        expect_enables(SCL_OEN, exp);
        run_cycles(2 * FILTER_LEN);
    endtask

    // a master scl pull inside the hold window must not reach the slave
    task automatic pull_scl_in_hold();
        m_dev_scl = 1'b0;
        watch_enables(SCL_OEN, SCL_OEN, 2 * FILTER_LEN);
        m_dev_scl = 1'b1;
        watch_enables(SCL_OEN, SCL_OEN, SCL_HOLD_CYCLES);
    endtask

    task automatic send_byte(input logic [7:0] data, input logic ack_bit);
        for (int i = 7; i >= 0; i--) begin
            drive_sda(1'b0, data[i]);
            set_scl(1'b1);
            set_scl(1'b0);
        end
        // slave answers on the ninth clock
        drive_sda(1'b0, 1'b1);
        drive_sda(1'b1, ack_bit);
        set_scl(1'b1);
        set_scl(1'b0);
        drive_sda(1'b1, 1'b1);
    endtask

    task automatic transfer(input int nbytes);
        logic [7:0] data;
        logic       ack_bit;
        drive_sda(1'b0, 1'b0);
        set_scl(1'b0);
        for (int n = 0; n < nbytes; n++) begin
            for (int k = 0; k < 8; k++) begin
                data[k] = rand_bit();
            end
            ack_bit = rand_bit();
            send_byte(data, ack_bit);
        end
        // stop condition ends the transfer
        drive_sda(1'b0, 1'b0);
        set_scl(1'b1);
        drive_sda(1'b0, 1'b1);
        pull_scl_in_hold();
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - err_before);
        end
    endtask

    initial begin
        int err_before;
        clk = 1'b0;
        rst_n = 1'b0;
        m_dev_scl = 1'b1;
        m_dev_sda = 1'b1;
        s_dev_scl = 1'b1;
        s_dev_sda = 1'b1;
        lfsr = LFSR_SEED;
        errors = 0;
        checks = 0;
        tests = 0;
        run_cycles(2);
        rst_n = 1'b1;

        err_before = errors;
        watch_enables(ALL_OEN, ALL_OEN, 20);
        finish_test("reset state", err_before);

        err_before = errors;
        drive_sda(1'b0, 1'b0);
        drive_sda(1'b0, 1'b1);
        // slave pull inside the hold window
        s_dev_sda = 1'b0;
        watch_enables(4'b0001 << M_SDA, 4'b0001 << M_SDA, 2 * FILTER_LEN);
        s_dev_sda = 1'b1;
        watch_enables(4'b0001 << M_SDA, 4'b0001 << M_SDA, SDA_HOLD_CYCLES);
        finish_test("master to slave sda", err_before);
        run_cycles(GAP_CYCLES);

        err_before = errors;
        drive_sda(1'b1, 1'b0);
        drive_sda(1'b1, 1'b1);
        m_dev_sda = 1'b0;
        watch_enables(4'b0001 << S_SDA, 4'b0001 << S_SDA, 2 * FILTER_LEN);
        m_dev_sda = 1'b1;
        watch_enables(4'b0001 << S_SDA, 4'b0001 << S_SDA, SDA_HOLD_CYCLES);
        finish_test("slave to master sda", err_before);
        run_cycles(GAP_CYCLES);

        err_before = errors;
        m_dev_sda = 1'b0;
        watch_enables(ALL_OEN, ALL_OEN, FILTER_LEN - 3);
        m_dev_sda = 1'b1;
        watch_enables(ALL_OEN, ALL_OEN, 4 * FILTER_LEN);
        finish_test("glitch rejection", err_before);

        err_before = errors;
        set_scl(1'b0);
        for (int i = 0; i < 16; i++) begin
            set_scl(rand_bit());
        end
        set_scl(1'b0);
        drive_sda(1'b0, 1'b0);
        set_scl(1'b1);
        drive_sda(1'b0, 1'b1);
        pull_scl_in_hold();
        finish_test("scl forwarding and stop", err_before);
        run_cycles(GAP_CYCLES);

        err_before = errors;
        for (int t = 0; t < 3; t++) begin
            transfer(2);
            run_cycles(GAP_CYCLES);
        end
        finish_test("random byte transfers", err_before);

        $display("tests %0d checks %0d errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* tb.f */
rtl/i2c_switch_pkg.sv
rtl/pad_filter.sv
rtl/sda_direction_fsm.sv
rtl/scl_forward_fsm.sv
rtl/i2c_switch_top.sv
sim/tb_i2c_switch.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 -Wno-fatal --top-module tb_i2c_switch -f tb.f -Mdir obj_dir
./obj_dir/Vtb_i2c_switch > sim.log
cat sim.log

if grep -q "^NO ERRORS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
